// File: Bender.yml
package:
  name: maze_renderer

sources:
  - files:
      - hdl/render_pkg.sv
      - hdl/sprite_rom.sv
      - hdl/position_store.sv
      - hdl/block_scanner.sv
      - hdl/render_sequencer.sv
      - hdl/pixel_pipe.sv
      - hdl/renderer_top.sv
  - target: test
    files:
      - bench/tb_bg_memory.sv
      - bench/tb_renderer.sv

// File: bench/tb_bg_memory.sv
`timescale 1ns/1ns

module tb_bg_memory
    import render_pkg::*;
(
    input  logic                 clock,
    input  logic                 enable,
    input  logic [COORD_X_W-1:0] x,
    input  logic [COORD_Y_W-1:0] y,
    output logic [COLOR_W-1:0]   color
);

    // Background colour for a pixel, every address bit takes part
    function automatic logic [COLOR_W-1:0] pattern_color(input logic [COORD_X_W-1:0] px,
                                                         input logic [COORD_Y_W-1:0] py);
        return {py, 5'b00000} ^ {4'h0, px} ^ 12'h4B6;
    endfunction

    initial color = '0;

    // One enabled cycle of read latency
    always @(posedge clock) begin
        if (enable) begin
            color <= pattern_color(x, y);
        end
    end

endmodule

// File: bench/tb_renderer.sv
`timescale 1ns/1ns

module tb_renderer
    import render_pkg::*;
();

    localparam int FRAME_TIMEOUT = 100000;

    logic                       clock;
    logic                       resetn;
    logic                       enable;
    logic [3:0][TILE_X_W-1:0]   pos_x;
    logic [3:0][TILE_Y_W-1:0]   pos_y;
    logic [3:0][TILE_X_W-1:0]   last_x;
    logic [3:0][TILE_Y_W-1:0]   last_y;
    logic [COORD_X_W-1:0]       bg_x;
    logic [COORD_Y_W-1:0]       bg_y;
    logic [COLOR_W-1:0]         bg_color;
    logic [COORD_X_W-1:0]       vga_x;
    logic [COORD_Y_W-1:0]       vga_y;
    logic [COLOR_W-1:0]         vga_color;
    logic                       plot;
    logic                       finished;

    // Expected pixels, in plot order
    int                         exp_x[$];
    int                         exp_y[$];
    logic [COLOR_W-1:0]         exp_c[$];
    logic                       end_due;

    // Memory addresses of the last two enabled cycles
    logic [COORD_X_W-1:0]       addr_x_q1;
    logic [COORD_X_W-1:0]       addr_x_q2;
    logic [COORD_Y_W-1:0]       addr_y_q1;
    logic [COORD_Y_W-1:0]       addr_y_q2;

    renderer_top dut0 (
        .clock     (clock),
        .resetn    (resetn),
        .enable    (enable),
        .player_x  (pos_x[0]),
        .player_y  (pos_y[0]),
        .ghost1_x  (pos_x[1]),
        .ghost1_y  (pos_y[1]),
        .ghost2_x  (pos_x[2]),
        .ghost2_y  (pos_y[2]),
        .ghost3_x  (pos_x[3]),
        .ghost3_y  (pos_y[3]),
        .bg_x      (bg_x),
        .bg_y      (bg_y),
        .bg_color  (bg_color),
        .vga_x     (vga_x),
        .vga_y     (vga_y),
        .vga_color (vga_color),
        .plot      (plot),
        .finished  (finished)
    );

    tb_bg_memory mem0 (
        .clock  (clock),
        .enable (enable),
        .x      (bg_x),
        .y      (bg_y),
        .color  (bg_color)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Pattern colours straight from the sprite descriptions
    function automatic logic [COLOR_W-1:0] sprite_pixel(input int sprite, input int col,
                                                        input int row);
        if (sprite == 0) begin
            if (row == 2 || col == 2 || ((row == 1 || row == 3) && col >= 1 && col <= 3))
                return COLOR_YELLOW;
            return COLOR_BROWN;
        end
        if (row == 2 && col == 2)
            return COLOR_RED;
        if (row <= 1 && (col == 0 || col == 4))
            return COLOR_BROWN;
        if (row == 4 && (col == 1 || col == 3))
            return COLOR_BROWN;
        return COLOR_WHITE;
    endfunction

    function automatic void push_pixel(input int x, input int y, input logic [COLOR_W-1:0] c);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_c.push_back(c);
    endfunction

    // Reference frame: background once, erase old spots, draw new ones
    function automatic void build_frame(input bit first);
        int px;
        int py;
        if (first) begin
            for (int y = 0; y < SCREEN_H; y++)
                for (int x = 0; x < SCREEN_W; x++)
                    push_pixel(x, y, mem0.pattern_color(COORD_X_W'(x), COORD_Y_W'(y)));
        end
        for (int s = 0; s < 4; s++) begin
            for (int dy = 0; dy < TILE_SIZE; dy++) begin
                for (int dx = 0; dx < TILE_SIZE; dx++) begin
                    px = last_x[s] * TILE_SIZE + dx;
                    py = last_y[s] * TILE_SIZE + dy;
                    push_pixel(px, py, mem0.pattern_color(COORD_X_W'(px), COORD_Y_W'(py)));
                end
            end
        end
        for (int s = 0; s < 4; s++) begin
            for (int dy = 0; dy < TILE_SIZE; dy++)
                for (int dx = 0; dx < TILE_SIZE; dx++)
                    push_pixel(pos_x[s] * TILE_SIZE + dx, pos_y[s] * TILE_SIZE + dy,
                               sprite_pixel(s, dx, dy));
        end
        last_x = pos_x;
        last_y = pos_y;
    endfunction

    function automatic void move_sprites();
        for (int s = 0; s < 4; s++) begin
            pos_x[s] = TILE_X_W'($urandom % (1 << TILE_X_W));
            pos_y[s] = TILE_Y_W'($urandom % (1 << TILE_Y_W));
        end
    endfunction

    // Returns on the rising edge that samples finished high
    task automatic wait_for_finished(input bit with_gaps);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clock);
            seen = finished;
            cycles++;
            if (!seen && cycles >= FRAME_TIMEOUT)
                stop_with_error("finished never arrived before the timeout");
            if (!seen) begin
                @(negedge clock);
                if (with_gaps)
                    enable = ($urandom % 4) != 0;
            end
        end
    endtask

    // Compare every plotted pixel, its memory address and the finished pulse
    always @(posedge clock) begin
        if (resetn && enable) begin
            check_value("finished", finished, end_due);
            end_due = 1'b0;
            if (plot) begin
                if (exp_x.size() == 0)
                    stop_with_error("plot went high with no pixel left in the frame");
                // Address went to the memory two enabled cycles earlier
                check_value("bg_x", addr_x_q2, exp_x[0]);
                check_value("bg_y", addr_y_q2, exp_y[0]);
                check_value("vga_x", vga_x, exp_x.pop_front());
                check_value("vga_y", vga_y, exp_y.pop_front());
                check_value("vga_color", vga_color, exp_c.pop_front());
                end_due = (exp_x.size() == 0);
            end
            addr_x_q2 = addr_x_q1;
            addr_y_q2 = addr_y_q1;
            addr_x_q1 = bg_x;
            addr_y_q1 = bg_y;
        end else if (resetn) begin
            check_value("plot", plot, 0);
            check_value("finished", finished, 0);
        end
    end

    initial begin
        int unsigned seed_value;
        seed_value = $urandom(32'h5628a123);
        resetn = 1'b0;
        enable = 1'b0;
        end_due = 1'b0;
        pos_x = {5'd31, 5'd20, 5'd10, 5'd2};
        pos_y = {4'd15, 4'd8, 4'd5, 4'd3};
        // Reset positions: player (0,0), ghosts (1,1)
        last_x = {5'd1, 5'd1, 5'd1, 5'd0};
        last_y = {4'd1, 4'd1, 4'd1, 4'd0};
        repeat (10) @(negedge clock);
        resetn = 1'b1;

        // Quiet outputs before the first frame
        repeat (5) begin
            @(posedge clock);
            check_value("vga_x", vga_x, 0);
            check_value("vga_y", vga_y, 0);
            check_value("vga_color", vga_color, 0);
        end

        @(negedge clock);
        build_frame(1'b1);
        enable = 1'b1;
        wait_for_finished(1'b0);
        @(negedge clock);

        // Frames 1 and 2 run steadily, the rest with enable gaps
        for (int frame = 1; frame < 6; frame++) begin
            move_sprites();
            build_frame(1'b0);
            enable = (frame < 3) ? 1'b1 : (($urandom % 4) != 0);
            wait_for_finished(frame >= 3);
            @(negedge clock);
        end

        enable = 1'b0;
        repeat (4) @(posedge clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: filelist.f
hdl/render_pkg.sv
hdl/sprite_rom.sv
hdl/position_store.sv
hdl/block_scanner.sv
hdl/render_sequencer.sv
hdl/pixel_pipe.sv
hdl/renderer_top.sv
bench/tb_bg_memory.sv
bench/tb_renderer.sv

// File: hdl/block_scanner.sv
`timescale 1ns/1ns

module block_scanner
    import render_pkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 enable,
    input  render_phase_e        phase,
    input  logic [TILE_X_W-1:0]  tile_x,
    input  logic [TILE_Y_W-1:0]  tile_y,
    output logic [COORD_X_W-1:0] pix_x,
    output logic [COORD_Y_W-1:0] pix_y,
    output logic [OFFSET_W-1:0]  dx,
    output logic [OFFSET_W-1:0]  dy,
    output logic                 pix_valid,
    output logic                 block_done,
    output logic                 screen_done
);

    logic [COORD_X_W-1:0] scan_x;
    logic [COORD_Y_W-1:0] scan_y;
    logic                 in_screen;
    logic                 in_block;
    logic                 row_end;
    logic                 tile_row_end;

    assign in_screen = (phase == PHASE_BACKGROUND);
    assign in_block  = (phase == PHASE_ERASE) || (phase == PHASE_DRAW);
    assign pix_valid = in_screen || in_block;

    assign row_end      = (scan_x == COORD_X_W'(SCREEN_W - 1));
    assign tile_row_end = (dx == OFFSET_W'(TILE_SIZE - 1));

    assign screen_done = in_screen && row_end && (scan_y == COORD_Y_W'(SCREEN_H - 1));
    assign block_done  = in_block && tile_row_end && (dy == OFFSET_W'(TILE_SIZE - 1));

    // Tile origin times five plus the offset inside the tile
    assign pix_x = in_screen ? scan_x :
        COORD_X_W'(tile_x) * COORD_X_W'(TILE_SIZE) + COORD_X_W'(dx);
    assign pix_y = in_screen ? scan_y :
        COORD_Y_W'(tile_y) * COORD_Y_W'(TILE_SIZE) + COORD_Y_W'(dy);

    // Full screen raster
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            scan_x <= '0;
            scan_y <= '0;
        end else if (enable && in_screen) begin
            scan_x <= row_end ? '0 : scan_x + 1'b1;
            if (screen_done) begin
                scan_y <= '0;
            end else if (row_end) begin
                scan_y <= scan_y + 1'b1;
            end
        end
    end

    // 5x5 walk through one sprite block
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            dx <= '0;
            dy <= '0;
        end else if (enable && in_block) begin
            dx <= tile_row_end ? '0 : dx + 1'b1;
            if (block_done) begin
                dy <= '0;
            end else if (tile_row_end) begin
                dy <= dy + 1'b1;
            end
        end
    end

endmodule

// File: hdl/pixel_pipe.sv
`timescale 1ns/1ns

module pixel_pipe
    import render_pkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 enable,
    input  render_phase_e        phase,
    input  logic [COORD_X_W-1:0] pix_x,
    input  logic [COORD_Y_W-1:0] pix_y,
    input  logic                 pix_valid,
    input  logic [COLOR_W-1:0]   sprite_color,
    input  logic [COLOR_W-1:0]   bg_color,
    output logic [COORD_X_W-1:0] bg_x,
    output logic [COORD_Y_W-1:0] bg_y,
    output logic [COORD_X_W-1:0] vga_x,
    output logic [COORD_Y_W-1:0] vga_y,
    output logic [COLOR_W-1:0]   vga_color,
    output logic                 plot
);

    logic [COORD_X_W-1:0] s1_x;
    logic [COORD_Y_W-1:0] s1_y;
    logic [COLOR_W-1:0]   s1_color;
    logic                 s1_draw;
    logic                 s1_valid;
    logic                 s2_valid;

    // Memory sees the address in the same cycle, data returns next cycle
    assign bg_x = pix_x;
    assign bg_y = pix_y;

    // Stage 1 lines up with the background read
    always_ff @(posedge clock) begin
        if (enable) begin
            s1_x     <= pix_x;
            s1_y     <= pix_y;
            s1_color <= sprite_color;
            s1_draw  <= (phase == PHASE_DRAW);
        end
    end

    // Stage 2 drives the display
    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            vga_x     <= '0;
            vga_y     <= '0;
            vga_color <= '0;
        end else if (enable) begin
            s1_valid  <= pix_valid;
            s2_valid  <= s1_valid;
            vga_x     <= s1_x;
            vga_y     <= s1_y;
            vga_color <= s1_draw ? s1_color : bg_color;
        end
    end

    assign plot = s2_valid && enable;

endmodule

// File: hdl/position_store.sv
`timescale 1ns/1ns

module position_store
    import render_pkg::*;
(
    input  logic                clock,
    input  logic                resetn,
    input  logic                enable,
    input  render_phase_e       phase,
    input  sprite_e             sprite_sel,
    input  logic                block_done,
    input  logic [TILE_X_W-1:0] player_x,
    input  logic [TILE_Y_W-1:0] player_y,
    input  logic [TILE_X_W-1:0] ghost1_x,
    input  logic [TILE_Y_W-1:0] ghost1_y,
    input  logic [TILE_X_W-1:0] ghost2_x,
    input  logic [TILE_Y_W-1:0] ghost2_y,
    input  logic [TILE_X_W-1:0] ghost3_x,
    input  logic [TILE_Y_W-1:0] ghost3_y,
    output logic [TILE_X_W-1:0] tile_x,
    output logic [TILE_Y_W-1:0] tile_y
);

    // Last drawn tile of each sprite, indexed by sprite_e
    logic [TILE_X_W-1:0] last_x [4];
    logic [TILE_Y_W-1:0] last_y [4];
    logic [TILE_X_W-1:0] live_x;
    logic [TILE_Y_W-1:0] live_y;

    always_comb begin
        case (sprite_sel)
            SPRITE_PLAYER: {live_x, live_y} = {player_x, player_y};
            SPRITE_GHOST1: {live_x, live_y} = {ghost1_x, ghost1_y};
            SPRITE_GHOST2: {live_x, live_y} = {ghost2_x, ghost2_y};
            default:       {live_x, live_y} = {ghost3_x, ghost3_y};
        endcase
    end

    // Erase uses the old spot, draw uses the new one
    assign tile_x = (phase == PHASE_DRAW) ? live_x : last_x[sprite_sel];
    assign tile_y = (phase == PHASE_DRAW) ? live_y : last_y[sprite_sel];

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            // Player starts at (0,0), ghosts at (1,1)
            for (int i = 0; i < 4; i++) begin
                last_x[i] <= (i == 0) ? TILE_X_W'(0) : TILE_X_W'(1);
                last_y[i] <= (i == 0) ? TILE_Y_W'(0) : TILE_Y_W'(1);
            end
        end else if (enable && phase == PHASE_DRAW && block_done) begin
            last_x[sprite_sel] <= live_x;
            last_y[sprite_sel] <= live_y;
        end
    end

endmodule

// File: hdl/render_pkg.sv
package render_pkg;

    // Display geometry
    parameter int SCREEN_W  = 160;
    parameter int SCREEN_H  = 120;
    parameter int TILE_SIZE = 5;

    // Coordinate widths
    parameter int COORD_X_W = 8;
    parameter int COORD_Y_W = 7;
    parameter int TILE_X_W  = 5;
    parameter int TILE_Y_W  = 4;
    parameter int OFFSET_W  = 3;

    // 4 bits each of red, green and blue
    parameter int COLOR_W = 12;

    // Sprite pattern colours
    parameter logic [COLOR_W-1:0] COLOR_BROWN  = 12'h531;
    parameter logic [COLOR_W-1:0] COLOR_YELLOW = 12'hFF3;
    parameter logic [COLOR_W-1:0] COLOR_WHITE  = 12'hFFF;
    parameter logic [COLOR_W-1:0] COLOR_RED    = 12'hF88;

    // Frame phases
    typedef enum logic [2:0] {
        PHASE_IDLE,
        PHASE_BACKGROUND,
        PHASE_ERASE,
        PHASE_DRAW,
        PHASE_DRAIN
    } render_phase_e;

    // Sprite order inside the erase and draw phases
    typedef enum logic [1:0] {
        SPRITE_PLAYER,
        SPRITE_GHOST1,
        SPRITE_GHOST2,
        SPRITE_GHOST3
    } sprite_e;

endpackage

// File: hdl/render_sequencer.sv
`timescale 1ns/1ns

module render_sequencer
    import render_pkg::*;
(
    input  logic          clock,
    input  logic          resetn,
    input  logic          enable,
    input  logic          block_done,
    input  logic          screen_done,
    output render_phase_e phase,
    output sprite_e       sprite_sel,
    output logic          finished
);

    logic    first_frame;
    logic    drain_cnt;
    logic    done_q;
    sprite_e next_sprite;

    assign next_sprite = sprite_e'(sprite_sel + 1'b1);

    // Pulse shows only on an enabled cycle
    assign finished = done_q && enable;

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            phase       <= PHASE_IDLE;
            sprite_sel  <= SPRITE_PLAYER;
            first_frame <= 1'b1;
            drain_cnt   <= 1'b0;
            done_q      <= 1'b0;
        end else if (enable) begin
            done_q <= 1'b0;
            case (phase)
                PHASE_IDLE: begin
                    sprite_sel <= SPRITE_PLAYER;
                    // Background is painted once after reset
                    phase <= first_frame ? PHASE_BACKGROUND : PHASE_ERASE;
                end
                PHASE_BACKGROUND: begin
                    if (screen_done) begin
                        first_frame <= 1'b0;
                        phase       <= PHASE_ERASE;
                    end
                end
                PHASE_ERASE: begin
                    if (block_done) begin
                        sprite_sel <= next_sprite;
                        if (sprite_sel == SPRITE_GHOST3) begin
                            phase <= PHASE_DRAW;
                        end
                    end
                end
                PHASE_DRAW: begin
                    if (block_done) begin
                        sprite_sel <= next_sprite;
                        if (sprite_sel == SPRITE_GHOST3) begin
                            phase     <= PHASE_DRAIN;
                            drain_cnt <= 1'b0;
                        end
                    end
                end
                PHASE_DRAIN: begin
                    // Two cycles for the last pixel to leave the pipe
                    if (drain_cnt) begin
                        phase  <= PHASE_IDLE;
                        done_q <= 1'b1;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                default: begin
                    phase <= PHASE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hdl/renderer_top.sv
`timescale 1ns/1ns

module renderer_top
    import render_pkg::*;
(
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 enable,
    input  logic [TILE_X_W-1:0]  player_x,
    input  logic [TILE_Y_W-1:0]  player_y,
    input  logic [TILE_X_W-1:0]  ghost1_x,
    input  logic [TILE_Y_W-1:0]  ghost1_y,
    input  logic [TILE_X_W-1:0]  ghost2_x,
    input  logic [TILE_Y_W-1:0]  ghost2_y,
    input  logic [TILE_X_W-1:0]  ghost3_x,
    input  logic [TILE_Y_W-1:0]  ghost3_y,
    output logic [COORD_X_W-1:0] bg_x,
    output logic [COORD_Y_W-1:0] bg_y,
    input  logic [COLOR_W-1:0]   bg_color,
    output logic [COORD_X_W-1:0] vga_x,
    output logic [COORD_Y_W-1:0] vga_y,
    output logic [COLOR_W-1:0]   vga_color,
    output logic                 plot,
    output logic                 finished
);

    render_phase_e        phase;
    sprite_e              sprite_sel;
    logic                 block_done;
    logic                 screen_done;
    logic                 pix_valid;
    logic [COORD_X_W-1:0] pix_x;
    logic [COORD_Y_W-1:0] pix_y;
    logic [OFFSET_W-1:0]  dx;
    logic [OFFSET_W-1:0]  dy;
    logic [TILE_X_W-1:0]  tile_x;
    logic [TILE_Y_W-1:0]  tile_y;
    logic [COLOR_W-1:0]   sprite_color;

    render_sequencer sequencer0 (
        .clock       (clock),
        .resetn      (resetn),
        .enable      (enable),
        .block_done  (block_done),
        .screen_done (screen_done),
        .phase       (phase),
        .sprite_sel  (sprite_sel),
        .finished    (finished)
    );

    block_scanner scanner0 (
        .clock       (clock),
        .resetn      (resetn),
        .enable      (enable),
        .phase       (phase),
        .tile_x      (tile_x),
        .tile_y      (tile_y),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .dx          (dx),
        .dy          (dy),
        .pix_valid   (pix_valid),
        .block_done  (block_done),
        .screen_done (screen_done)
    );

    position_store positions0 (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .phase      (phase),
        .sprite_sel (sprite_sel),
        .block_done (block_done),
        .player_x   (player_x),
        .player_y   (player_y),
        .ghost1_x   (ghost1_x),
        .ghost1_y   (ghost1_y),
        .ghost2_x   (ghost2_x),
        .ghost2_y   (ghost2_y),
        .ghost3_x   (ghost3_x),
        .ghost3_y   (ghost3_y),
        .tile_x     (tile_x),
        .tile_y     (tile_y)
    );

    sprite_rom rom0 (
        .dx           (dx),
        .dy           (dy),
        .sprite_sel   (sprite_sel),
        .sprite_color (sprite_color)
    );

    pixel_pipe pipe0 (
        .clock        (clock),
        .resetn       (resetn),
        .enable       (enable),
        .phase        (phase),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pix_valid    (pix_valid),
        .sprite_color (sprite_color),
        .bg_color     (bg_color),
        .bg_x         (bg_x),
        .bg_y         (bg_y),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .vga_color    (vga_color),
        .plot         (plot)
    );

endmodule

// File: hdl/sprite_rom.sv
`timescale 1ns/1ns

module sprite_rom
    import render_pkg::*;
(
    input  logic [OFFSET_W-1:0] dx,
    input  logic [OFFSET_W-1:0] dy,
    input  sprite_e             sprite_sel,
    output logic [COLOR_W-1:0]  sprite_color
);

    // Row masks, bit index is the column
    logic [4:0] player_yellow;
    logic [4:0] ghost_brown;
    logic       ghost_red;

    // Player is a yellow cross with a filled middle ring
    always_comb begin
        case (dy)
            3'd0, 3'd4: player_yellow = 5'b00100;
            3'd1, 3'd3: player_yellow = 5'b01110;
            3'd2:       player_yellow = 5'b11111;
            default:    player_yellow = 5'b00000;
        endcase
    end

    // Ghost body is white with brown corners and feet
    always_comb begin
        case (dy)
            3'd0, 3'd1: ghost_brown = 5'b10001;
            3'd4:       ghost_brown = 5'b01010;
            default:    ghost_brown = 5'b00000;
        endcase
    end

    // Red eye at the centre
    assign ghost_red = (dx == 3'd2) && (dy == 3'd2);

    always_comb begin
        if (sprite_sel == SPRITE_PLAYER) begin
            sprite_color = player_yellow[dx] ? COLOR_YELLOW : COLOR_BROWN;
        end else if (ghost_red) begin
            sprite_color = COLOR_RED;
        end else begin
            sprite_color = ghost_brown[dx] ? COLOR_BROWN : COLOR_WHITE;
        end
    end

endmodule
